// ==== run.sh ====
#!/bin/sh
# Build and run the register-read stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module regReadTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VregReadTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "*** FAILED ***" "$LOG"; then
  exit 1
fi
exit 0

// ==== src.f ====
+incdir+verilog
verilog/issuePkg.sv
verilog/writebackPkg.sv
verilog/physRegFile.sv
verilog/bypassNetwork.sv
verilog/readyTable.sv
verilog/regReadLatch.sv
verilog/regReadStage.sv
test/regReadTb.sv

// ==== test/regReadTb.sv ====
`timescale 1ns/100ps

`include "regRead_consts.svh"

module regReadTb;

  localparam int numCycles = 3000;
  localparam int resetCycles = 3;
  localparam int limitNs = (numCycles + resetCycles + 40) * 8;

  localparam logic [`PHYS_REGS-1:0] readyAfterReset =
    {{(`PHYS_REGS-`ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}};

  logic                    clk;
  logic                    rstN;
  issuePkg::issuePacketS   issue    [`NUM_LANES];
  logic [`NUM_LANES-1:0]   issueValid;
  writebackPkg::wbPacketS  wb       [`NUM_WB_PORTS];
  writebackPkg::regTagS    unmap    [`NUM_WB_PORTS];
  writebackPkg::regTagS    readyTag [`NUM_WB_PORTS];
  issuePkg::ctrlResolveS   resolve;
  logic                    recoverFlag;
  logic                    exceptionFlag;
  issuePkg::operandPacketS operand  [`NUM_LANES];
  logic [`NUM_LANES-1:0]   operandValid;
  logic [`PHYS_REGS-1:0]   phyRegRdy;

  // Reference model state.
  logic [`DATA_WIDTH-1:0]  shadowRegs [`PHYS_REGS];
  logic [`PHYS_REGS-1:0]   shadowReady;
  issuePkg::operandPacketS expOperand [`NUM_LANES];
  logic [`NUM_LANES-1:0]   expValid;

  integer seed;
  int     errors;
  int     checks;

  regReadStage dut (
    .clk             (clk),
    .rstN_i          (rstN),
    .issue_i         (issue),
    .issueValid_i    (issueValid),
    .wb_i            (wb),
    .unmap_i         (unmap),
    .readyTag_i      (readyTag),
    .resolve_i       (resolve),
    .recoverFlag_i   (recoverFlag),
    .exceptionFlag_i (exceptionFlag),
    .operand_o       (operand),
    .operandValid_o  (operandValid),
    .phyRegRdy_o     (phyRegRdy)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] randWord();
    return $random(seed);
  endfunction

  // Half the tags land in 0..3 so writebacks and sources collide often.
  function automatic issuePkg::physTagT randTag();
    logic [31:0] r;
    r = randWord();
    if (r[5]) begin
      return `PHYS_REG_LOG'(r[1:0]);
    end
    return r[`PHYS_REG_LOG-1:0];
  endfunction

  // Register contents with same-cycle writebacks applied, port 1 last.
  function automatic logic [`DATA_WIDTH-1:0] forwardValue(input issuePkg::physTagT tag);
    logic [`DATA_WIDTH-1:0] v;
    v = shadowRegs[tag];
    for (int p = 0; p < `NUM_WB_PORTS; p++) begin
      if (wb[p].valid && wb[p].dest == tag) begin
        v = wb[p].data;
      end
    end
    return v;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic driveInputs();
    logic [31:0] r;
    for (int l = 0; l < `NUM_LANES; l++) begin
      r = randWord();
      issue[l].branchMask = r[`CHECKPOINTS-1:0];
      issue[l].opcode = issuePkg::opcodeE'(r[6:4]);
      issue[l].imm = r[31:16];
      issue[l].src1 = randTag();
      issue[l].src2 = randTag();
      issue[l].dest = randTag();
      issueValid[l] = r[7] | r[8];
    end
    for (int p = 0; p < `NUM_WB_PORTS; p++) begin
      r = randWord();
      wb[p].valid = r[0] | r[1];
      wb[p].dest = randTag();
      wb[p].data = randWord();
      unmap[p].valid = r[2];
      unmap[p].tag = randTag();
      readyTag[p].valid = r[3];
      readyTag[p].tag = randTag();
    end
    r = randWord();
    resolve.verified = r[0];
    resolve.mispredict = r[1];
    resolve.checkpointId = r[`CHECKPOINTS_LOG+1:2];
    recoverFlag = (r[7:5] == 3'd0);
    exceptionFlag = (r[12:8] == 5'd0);
  endtask

  task automatic checkOutputs();
    checkValue("operandValid_o", 64'(expValid), 64'(operandValid));
    for (int l = 0; l < `NUM_LANES; l++) begin
      if (expValid[l]) begin
        checkValue($sformatf("operand_o[%0d].inst", l),
                   64'(expOperand[l].inst), 64'(operand[l].inst));
        checkValue($sformatf("operand_o[%0d].data1", l),
                   64'(expOperand[l].data1), 64'(operand[l].data1));
        checkValue($sformatf("operand_o[%0d].data2", l),
                   64'(expOperand[l].data2), 64'(operand[l].data2));
      end
    end
    checkValue("phyRegRdy_o", 64'(shadowReady), 64'(phyRegRdy));
  endtask

  // Expected outputs for the next cycle, then the edge's state update.
  task automatic updateModel();
    logic mispredict;
    mispredict = resolve.verified && resolve.mispredict;
    for (int l = 0; l < `NUM_LANES; l++) begin
      expOperand[l].inst = issue[l];
      expOperand[l].data1 = forwardValue(issue[l].src1);
      expOperand[l].data2 = forwardValue(issue[l].src2);
      expValid[l] = issueValid[l] && !(mispredict && issue[l].branchMask[resolve.checkpointId]);
    end
    if (!recoverFlag) begin
      for (int p = 0; p < `NUM_WB_PORTS; p++) begin
        if (wb[p].valid) begin
          shadowRegs[wb[p].dest] = wb[p].data;
        end
      end
    end
    if (exceptionFlag) begin
      shadowReady = readyAfterReset;
    end else begin
      for (int p = 0; p < `NUM_WB_PORTS; p++) begin
        if (unmap[p].valid) begin
          shadowReady[unmap[p].tag] = 1'b0;
        end
      end
      for (int p = 0; p < `NUM_WB_PORTS; p++) begin
        if (readyTag[p].valid) begin
          shadowReady[readyTag[p].tag] = 1'b1;
        end
      end
    end
  endtask

  initial begin
    seed = 32'h4708e471;
    errors = 0;
    checks = 0;
    clk = 1'b0;
    rstN = 1'b0;
    for (int l = 0; l < `NUM_LANES; l++) begin
      issue[l] = '0;
      expOperand[l] = '0;
    end
    for (int p = 0; p < `NUM_WB_PORTS; p++) begin
      wb[p] = '0;
      unmap[p] = '0;
      readyTag[p] = '0;
    end
    issueValid = '0;
    resolve = '0;
    recoverFlag = 1'b0;
    exceptionFlag = 1'b0;
    for (int i = 0; i < `PHYS_REGS; i++) begin
      shadowRegs[i] = '0;
    end
    shadowReady = readyAfterReset;
    expValid = '0;

    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1;

    for (int c = 0; c < numCycles; c++) begin
      driveInputs();
      #6;
      checkOutputs();
      updateModel();
      @(posedge clk);
      #1;
    end
    #6;
    checkOutputs();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(limitNs);
    $display("Timeout: the run did not finish within %0d ns", limitNs);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== verilog/bypassNetwork.sv ====
`timescale 1ns/100ps

`include "regRead_consts.svh"

module bypassNetwork (
  input  issuePkg::physTagT       srcTag_i   [2*`NUM_LANES],
  input  logic [`DATA_WIDTH-1:0]  fileData_i [2*`NUM_LANES],
  input  writebackPkg::wbPacketS  wb_i       [`NUM_WB_PORTS],
  output logic [`DATA_WIDTH-1:0]  opData_o   [2*`NUM_LANES]
);

  // One match bit per operand and writeback port.
  logic [`NUM_WB_PORTS-1:0] hit [2*`NUM_LANES];

  genvar o;
  genvar p;

  generate
    for (o = 0; o < 2*`NUM_LANES; o++) begin : genOperand
      for (p = 0; p < `NUM_WB_PORTS; p++) begin : genPort
        assign hit[o][p] = wb_i[p].valid && (wb_i[p].dest == srcTag_i[o]);
      end
    end
  endgenerate

  // Scan ports upward so the highest matching port is the one selected.
  always_comb begin
    for (int op = 0; op < 2*`NUM_LANES; op++) begin
      opData_o[op] = fileData_i[op];
      for (int wp = 0; wp < `NUM_WB_PORTS; wp++) begin
        if (hit[op][wp]) begin
          opData_o[op] = wb_i[wp].data;
        end
      end
    end
  end

endmodule

// ==== verilog/issuePkg.sv ====
`include "regRead_consts.svh"

package issuePkg;

  // Carried through the stage untouched.
  typedef enum logic [2:0] {
    ADD    = 3'd0,
    SUB    = 3'd1,
    AND    = 3'd2,
    OR     = 3'd3,
    LOAD   = 3'd4,
    STORE  = 3'd5,
    BRANCH = 3'd6,
    NOP    = 3'd7
  } opcodeE;

  typedef logic [`PHYS_REG_LOG-1:0] physTagT;

  typedef struct packed {
    logic [`CHECKPOINTS-1:0] branchMask;
    physTagT                 src1;
    physTagT                 src2;
    physTagT                 dest;
    opcodeE                  opcode;
    logic [`IMM_WIDTH-1:0]   imm;
  } issuePacketS;

  // Issue packet with its operand values attached.
  typedef struct packed {
    logic [`DATA_WIDTH-1:0] data2;
    logic [`DATA_WIDTH-1:0] data1;
    issuePacketS            inst;
  } operandPacketS;

  typedef struct packed {
    logic                        verified;
    logic                        mispredict;
    logic [`CHECKPOINTS_LOG-1:0] checkpointId;
  } ctrlResolveS;

endpackage

// ==== verilog/physRegFile.sv ====
`timescale 1ns/100ps

`include "regRead_consts.svh"

module physRegFile (
  input  logic                    clk,
  input  logic                    rstN_i,
  input  issuePkg::physTagT       rdTag_i   [2*`NUM_LANES],
  output logic [`DATA_WIDTH-1:0]  rdData_o  [2*`NUM_LANES],
  input  writebackPkg::wbPacketS  wb_i      [`NUM_WB_PORTS],
  input  logic                    recoverFlag_i
);

  logic [`DATA_WIDTH-1:0] regs [`PHYS_REGS];

  // Writes are dropped while the core recovers.
  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      for (int i = 0; i < `PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (!recoverFlag_i) begin
      // Higher port number is written last and wins.
      for (int p = 0; p < `NUM_WB_PORTS; p++) begin
        if (wb_i[p].valid) begin
          regs[wb_i[p].dest] <= wb_i[p].data;
        end
      end
    end
  end

  // Asynchronous reads, contents before this edge.
  always_comb begin
    for (int r = 0; r < 2*`NUM_LANES; r++) begin
      rdData_o[r] = regs[rdTag_i[r]];
    end
  end

endmodule

// ==== verilog/readyTable.sv ====
`timescale 1ns/100ps

`include "regRead_consts.svh"

module readyTable (
  input  logic                    clk,
  input  logic                    rstN_i,
  input  logic                    exceptionFlag_i,
  input  writebackPkg::regTagS    unmap_i    [`NUM_WB_PORTS],
  input  writebackPkg::regTagS    readyTag_i [`NUM_WB_PORTS],
  output logic [`PHYS_REGS-1:0]   phyRegRdy_o
);

  // Architectural registers hold committed values and start ready.
  localparam logic [`PHYS_REGS-1:0] resetPattern =
    {{(`PHYS_REGS-`ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}};

  logic [`PHYS_REGS-1:0] readyQ;
  logic [`PHYS_REGS-1:0] readyD;

  always_comb begin
    readyD = readyQ;
    if (exceptionFlag_i) begin
      readyD = resetPattern;
    end else begin
      for (int p = 0; p < `NUM_WB_PORTS; p++) begin
        if (unmap_i[p].valid) begin
          readyD[unmap_i[p].tag] = 1'b0;
        end
      end
      // Sets come after clears, so a set wins on the same tag.
      for (int p = 0; p < `NUM_WB_PORTS; p++) begin
        if (readyTag_i[p].valid) begin
          readyD[readyTag_i[p].tag] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      readyQ <= resetPattern;
    end else begin
      readyQ <= readyD;
    end
  end

  assign phyRegRdy_o = readyQ;

endmodule

// ==== verilog/regReadLatch.sv ====
`timescale 1ns/100ps

`include "regRead_consts.svh"

module regReadLatch (
  input  logic                     clk,
  input  logic                     rstN_i,
  input  issuePkg::operandPacketS  operand_i [`NUM_LANES],
  input  logic [`NUM_LANES-1:0]    valid_i,
  input  issuePkg::ctrlResolveS    resolve_i,
  output issuePkg::operandPacketS  operand_o [`NUM_LANES],
  output logic [`NUM_LANES-1:0]    valid_o
);

  logic                  mispredict;
  logic [`NUM_LANES-1:0] squash;

  assign mispredict = resolve_i.verified && resolve_i.mispredict;

  // Lane depends on the mispredicted checkpoint.
  always_comb begin
    for (int l = 0; l < `NUM_LANES; l++) begin
      squash[l] = mispredict && operand_i[l].inst.branchMask[resolve_i.checkpointId];
    end
  end

  always_ff @(posedge clk or negedge rstN_i) begin
    if (!rstN_i) begin
      valid_o <= '0;
    end else begin
      valid_o <= valid_i & ~squash;
    end
  end

  // Payload only, qualified by valid_o.
  always_ff @(posedge clk) begin
    for (int l = 0; l < `NUM_LANES; l++) begin
      operand_o[l] <= operand_i[l];
    end
  end

endmodule

// ==== verilog/regReadStage.sv ====
`timescale 1ns/100ps

`include "regRead_consts.svh"

module regReadStage (
  input  logic                     clk,
  input  logic                     rstN_i,
  input  issuePkg::issuePacketS    issue_i    [`NUM_LANES],
  input  logic [`NUM_LANES-1:0]    issueValid_i,
  input  writebackPkg::wbPacketS   wb_i       [`NUM_WB_PORTS],
  input  writebackPkg::regTagS     unmap_i    [`NUM_WB_PORTS],
  input  writebackPkg::regTagS     readyTag_i [`NUM_WB_PORTS],
  input  issuePkg::ctrlResolveS    resolve_i,
  input  logic                     recoverFlag_i,
  input  logic                     exceptionFlag_i,
  output issuePkg::operandPacketS  operand_o  [`NUM_LANES],
  output logic [`NUM_LANES-1:0]    operandValid_o,
  output logic [`PHYS_REGS-1:0]    phyRegRdy_o
);

  // Operand 2*l is src1 of lane l, 2*l+1 is src2.
  issuePkg::physTagT       srcTag   [2*`NUM_LANES];
  logic [`DATA_WIDTH-1:0]  fileData [2*`NUM_LANES];
  logic [`DATA_WIDTH-1:0]  opData   [2*`NUM_LANES];
  issuePkg::operandPacketS operand  [`NUM_LANES];

  genvar l;

  generate
    for (l = 0; l < `NUM_LANES; l++) begin : genLane
      assign srcTag[2*l]   = issue_i[l].src1;
      assign srcTag[2*l+1] = issue_i[l].src2;

      assign operand[l].inst  = issue_i[l];
      assign operand[l].data1 = opData[2*l];
      assign operand[l].data2 = opData[2*l+1];
    end
  endgenerate

  physRegFile regFile (
    .clk           (clk),
    .rstN_i        (rstN_i),
    .rdTag_i       (srcTag),
    .rdData_o      (fileData),
    .wb_i          (wb_i),
    .recoverFlag_i (recoverFlag_i)
  );

  // Forwarding sees writebacks even during recovery.
  bypassNetwork bypass (
    .srcTag_i   (srcTag),
    .fileData_i (fileData),
    .wb_i       (wb_i),
    .opData_o   (opData)
  );

  regReadLatch latch (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .operand_i (operand),
    .valid_i   (issueValid_i),
    .resolve_i (resolve_i),
    .operand_o (operand_o),
    .valid_o   (operandValid_o)
  );

  readyTable ready (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .exceptionFlag_i (exceptionFlag_i),
    .unmap_i         (unmap_i),
    .readyTag_i      (readyTag_i),
    .phyRegRdy_o     (phyRegRdy_o)
  );

endmodule

// ==== verilog/regRead_consts.svh ====
`ifndef REGREAD_CONSTS_SVH
`define REGREAD_CONSTS_SVH

// Issue lanes, and writeback, unmap and ready-tag ports.
`define NUM_LANES 2
`define NUM_WB_PORTS 2

// Physical registers and tag width.
`define PHYS_REGS 32
`define PHYS_REG_LOG 5

// Registers that are ready out of reset.
`define ARCH_REGS 8

`define DATA_WIDTH 32
`define CHECKPOINTS 4
`define CHECKPOINTS_LOG 2
`define IMM_WIDTH 16

`endif

// ==== verilog/writebackPkg.sv ====
`include "regRead_consts.svh"

package writebackPkg;

  // Result leaving a functional unit.
  typedef struct packed {
    logic                     valid;
    logic [`PHYS_REG_LOG-1:0] dest;
    logic [`DATA_WIDTH-1:0]   data;
  } wbPacketS;

  // Shared by the unmap and ready-tag ports.
  typedef struct packed {
    logic                     valid;
    logic [`PHYS_REG_LOG-1:0] tag;
  } regTagS;

endpackage
